/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// width of one slot in the CP0 register file
`define REG_DATA_WIDTH 32

// random resets to the top entry
`define TLB_ENTRIES_NUM 16

`define ZERO_WORD {`REG_DATA_WIDTH{1'b0}}

// cause.exc_code values
`define EXCCODE_INT  5'h00
`define EXCCODE_TLBL 5'h02
`define EXCCODE_TLBS 5'h03
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_OV   5'h0c

// handler locations
`define VEC_BEV_BASE       32'hbfc0_0200
`define VEC_OFFSET_GENERAL 32'h0000_0180

`endif

/* common/cpu_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`REG_DATA_WIDTH-1:0] Word_t;
	typedef logic Bit_t;
	typedef logic [4:0] RegAddr_t;

	typedef struct packed {
		logic [3:0] cu;
		logic [4:0] rsvd_27_23;
		logic       bev;
		logic [5:0] rsvd_21_16;
		logic [7:0] im;
		logic [2:0] rsvd_7_5;
		logic       um;
		logic       rsvd_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} Status_t;

	typedef struct packed {
		logic        bd;
		logic        rsvd_30;
		logic [1:0]  ce;
		logic [11:0] rsvd_27_16;
		logic [7:0]  ip;
		logic        rsvd_7;
		logic [4:0]  exc_code;
		logic [1:0]  rsvd_1_0;
	} Cause_t;

	// slot 0 (index) is the least significant word
	typedef struct packed {
		Word_t   error_epc;
		Word_t   config0;
		Word_t   ebase;
		Word_t   prid;
		Word_t   epc;
		Cause_t  cause;
		Status_t status;
		Word_t   compare;
		Word_t   entry_hi;
		Word_t   count;
		Word_t   bad_vaddr;
		Word_t   wired;
		Word_t   page_mask;
		Word_t   context_;
		Word_t   entry_lo1;
		Word_t   entry_lo0;
		Word_t   random;
		Word_t   index;
	} CP0Regs_t;

	typedef struct packed {
		Bit_t       we;
		logic [2:0] sel;
		RegAddr_t   waddr;
		Word_t      wdata;
	} CP0RegWriteReq_t;

	// raw fault and interrupt sources from the memory stage
	typedef struct packed {
		Bit_t       valid;
		Word_t      cur_pc;
		Bit_t       delayslot;
		Bit_t       eret;
		logic [7:0] hw_int;
		Bit_t       if_adel;
		Bit_t       ri;
		Bit_t       syscall;
		Bit_t       brk;
		Bit_t       ov;
		Bit_t       mem_adel;
		Bit_t       mem_ades;
		Bit_t       tlbl;
		Bit_t       tlbs;
		Word_t      bad_addr;
	} ExceptCauses_t;

	typedef struct packed {
		Bit_t       flush;
		Bit_t       eret;
		Bit_t       delayslot;
		Word_t      cur_pc;
		logic [4:0] code;
		Word_t      extra;
	} ExceptReq_t;

endpackage

`default_nettype wire

/* common/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

	// one TLB entry as returned by tlbr
	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        G;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
	} TLBEntry_t;

endpackage

`default_nettype wire

/* cp0/cp0_write_mask.sv */
`default_nettype none

`include "cpu_config.svh"

module cp0_write_mask (
	input  wire [2:0]              sel,
	input  wire cpu_pkg::RegAddr_t addr,
	output cpu_pkg::Word_t         mask
);

	always_comb
	begin
		mask = `ZERO_WORD;
		if (sel == 3'd0)
		begin
			case (addr)
				// index and wired hold a TLB entry number
				5'd0, 5'd6: mask = `REG_DATA_WIDTH'(`TLB_ENTRIES_NUM - 1);
				// entry_lo0/1, entry_hi, compare, epc, error_epc
				5'd2, 5'd3, 5'd10, 5'd11, 5'd14, 5'd30: mask = '1;
				// context pte_base
				5'd4: mask = 32'hff80_0000;
				// page_mask mask field
				5'd5: mask = 32'h1fff_e000;
				// cu, bev, im, um, erl, exl, ie
				5'd12: mask = 32'hf040_ff17;
				// software interrupt bits only
				5'd13: mask = 32'h0000_0300;
				default: mask = `ZERO_WORD;
			endcase
		end
	end

endmodule

`default_nettype wire

/* cp0/cp0.sv */
`default_nettype none

`include "cpu_config.svh"

module cp0 (
	input  wire                            clk,
	input  wire                            rst,
	input  wire cpu_pkg::RegAddr_t         raddr,
	input  wire [2:0]                      rsel,
	input  wire cpu_pkg::CP0RegWriteReq_t  wr,
	input  wire cpu_pkg::ExceptReq_t       except_req,
	input  wire cpu_pkg::Bit_t             tlbr_req,
	input  wire tlb_pkg::TLBEntry_t        tlbr_res,
	input  wire cpu_pkg::Bit_t             tlbp_req,
	input  wire cpu_pkg::Word_t            tlbp_res,
	output cpu_pkg::Word_t                 rdata,
	output cpu_pkg::CP0Regs_t              regs,
	output logic [7:0]                     asid,
	output cpu_pkg::Bit_t                  user_mode
);
	import cpu_pkg::*;

	localparam logic [4:0] NO_SLOT = 5'd31;

	CP0Regs_t   regs_next;
	Word_t      wmask;
	Word_t      wold;
	logic [4:0] rslot;
	logic [4:0] wslot;
	logic       addr_fault;
	logic       tlb_fault;

	// map register number and select onto a slot of CP0Regs_t
	function automatic logic [4:0] slot_of(input RegAddr_t addr, input logic [2:0] sel);
		logic [4:0] slot;
		slot = NO_SLOT;
		if (sel == 3'd0)
		begin
			case (addr)
				5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6: slot = addr;
				// no register at 7, so 8..15 shift down by one
				5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15: slot = addr - 5'd1;
				5'd16: slot = 5'd16;
				5'd30: slot = 5'd17;
				default: slot = NO_SLOT;
			endcase
		end
		else if (sel == 3'd1 && addr == 5'd15)
		begin
			slot = 5'd15;
		end
		return slot;
	endfunction

	assign rslot = slot_of(raddr, rsel);
	assign wslot = slot_of(wr.waddr, wr.sel);

	assign rdata = (rslot == NO_SLOT) ? `ZERO_WORD :
		regs[rslot * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];

	assign asid = regs.entry_hi[7:0];
	assign user_mode = (regs.status[4:1] == 4'b1000);

	cp0_write_mask write_mask_i (
		.sel  (wr.sel),
		.addr (wr.waddr),
		.mask (wmask)
	);

	assign addr_fault = (except_req.code == `EXCCODE_ADEL) || (except_req.code == `EXCCODE_ADES);
	assign tlb_fault = (except_req.code == `EXCCODE_TLBL) || (except_req.code == `EXCCODE_TLBS);

	// later updates override earlier ones
	always_comb
	begin
		regs_next = regs;
		wold = `ZERO_WORD;
		regs_next.count = regs.count + 32'd1;

		if (wr.we && wslot != NO_SLOT)
		begin
			wold = regs_next[wslot * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];
			regs_next[wslot * `REG_DATA_WIDTH +: `REG_DATA_WIDTH] =
				(wr.wdata & wmask) | (wold & ~wmask);
		end
		// ebase only exposes its base field to software
		if (wr.we && wr.waddr == 5'd15 && wr.sel == 3'd1)
			regs_next.ebase[29:12] = wr.wdata[29:12];

		if (tlbr_req)
		begin
			regs_next.entry_hi = {tlbr_res.vpn2, 5'b0, tlbr_res.asid};
			regs_next.entry_lo0 = {6'b0, tlbr_res.pfn0, tlbr_res.c0,
				tlbr_res.d0, tlbr_res.v0, tlbr_res.G};
			regs_next.entry_lo1 = {6'b0, tlbr_res.pfn1, tlbr_res.c1,
				tlbr_res.d1, tlbr_res.v1, tlbr_res.G};
		end
		if (tlbp_req)
			regs_next.index = tlbp_res;

		if (except_req.flush && except_req.eret)
		begin
			if (regs_next.status.erl)
				regs_next.status.erl = 1'b0;
			else
				regs_next.status.exl = 1'b0;
		end
		else if (except_req.flush)
		begin
			// nested exceptions keep the first return address
			if (!regs_next.status.exl)
			begin
				regs_next.cause.bd = except_req.delayslot;
				regs_next.epc = except_req.delayslot ? except_req.cur_pc - 32'd4 :
					except_req.cur_pc;
			end
			regs_next.status.exl = 1'b1;
			regs_next.cause.exc_code = except_req.code;
			regs_next.cause.ce = 2'b00;
			if (except_req.code == `EXCCODE_INT)
				regs_next.cause.ip = except_req.extra[7:0];
			if (addr_fault || tlb_fault)
				regs_next.bad_vaddr = except_req.extra;
			if (tlb_fault)
			begin
				regs_next.context_[22:4] = except_req.extra[31:13];
				regs_next.entry_hi[31:13] = except_req.extra[31:13];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs <= '0;
			regs.random <= `REG_DATA_WIDTH'(`TLB_ENTRIES_NUM - 1);
			// cu0 and bev
			regs.status <= Status_t'(32'h1040_0000);
			regs.ebase <= 32'h8000_0001;
		end
		else
		begin
			regs <= regs_next;
		end
	end

endmodule

`default_nettype wire

/* design/except_prioritizer.sv */
`default_nettype none

`include "cpu_config.svh"

module except_prioritizer (
	input  wire                          clk,
	input  wire                          rst,
	input  wire cpu_pkg::ExceptCauses_t  causes,
	input  wire cpu_pkg::CP0Regs_t       regs,
	output cpu_pkg::ExceptReq_t          except_req
);
	import cpu_pkg::*;

	logic [7:0] pending;
	logic       int_taken;
	ExceptReq_t req_next;

	assign pending = causes.hw_int & regs.status.im;
	// no interrupts while disabled or inside a handler
	assign int_taken = |pending && regs.status.ie && !regs.status.exl && !regs.status.erl;

	always_comb
	begin
		req_next = '0;
		req_next.cur_pc = causes.cur_pc;
		req_next.delayslot = causes.delayslot;
		req_next.flush = causes.valid;
		req_next.code = `EXCCODE_INT;
		if (int_taken)
		begin
			req_next.extra = Word_t'(pending);
		end
		else if (causes.if_adel)
		begin
			req_next.code = `EXCCODE_ADEL;
			req_next.extra = causes.cur_pc;
		end
		else if (causes.ri)
			req_next.code = `EXCCODE_RI;
		else if (causes.ov)
			req_next.code = `EXCCODE_OV;
		else if (causes.syscall)
			req_next.code = `EXCCODE_SYS;
		else if (causes.brk)
			req_next.code = `EXCCODE_BP;
		else if (causes.mem_adel || causes.mem_ades || causes.tlbl || causes.tlbs)
		begin
			req_next.extra = causes.bad_addr;
			if (causes.mem_adel)
				req_next.code = `EXCCODE_ADEL;
			else if (causes.mem_ades)
				req_next.code = `EXCCODE_ADES;
			else if (causes.tlbl)
				req_next.code = `EXCCODE_TLBL;
			else
				req_next.code = `EXCCODE_TLBS;
		end
		else if (causes.eret)
			req_next.eret = 1'b1;
		else
			req_next.flush = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		except_req <= req_next;
		if (rst)
			except_req.flush <= 1'b0;
	end

endmodule

`default_nettype wire

/* design/except_vector.sv */
`default_nettype none

`include "cpu_config.svh"

module except_vector (
	input  wire                       clk,
	input  wire                       rst,
	input  wire cpu_pkg::ExceptReq_t  except_req,
	input  wire cpu_pkg::CP0Regs_t    regs,
	output logic                      redirect_valid,
	output cpu_pkg::Word_t            redirect_pc
);
	import cpu_pkg::*;

	Word_t target;

	// regs still hold the values from before this request
	always_comb
	begin
		if (except_req.eret)
		begin
			if (regs.status.erl)
				target = regs.error_epc;
			else
				target = regs.epc;
		end
		else if (regs.status.bev)
		begin
			target = `VEC_BEV_BASE + `VEC_OFFSET_GENERAL;
		end
		else
		begin
			target = {regs.ebase[31:12], 12'h000} | `VEC_OFFSET_GENERAL;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			redirect_valid <= 1'b0;
		else
			redirect_valid <= except_req.flush;

		if (except_req.flush)
			redirect_pc <= target;
	end

endmodule

`default_nettype wire

/* design/cp0_bus_port.sv */
`default_nettype none

module cp0_bus_port (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cyc,
	input  wire                      stb,
	input  wire                      we,
	input  wire [7:0]                adr,
	input  wire cpu_pkg::Word_t      dat_w,
	output cpu_pkg::Word_t           dat_r,
	output logic                     ack,
	output cpu_pkg::CP0RegWriteReq_t wr,
	output cpu_pkg::RegAddr_t        raddr,
	output logic [2:0]               rsel,
	input  wire cpu_pkg::Word_t      rdata
);

	logic req;

	// a new request is one not already being acknowledged
	assign req = cyc && stb && !ack;

	assign raddr = adr[7:3];
	assign rsel = adr[2:0];

	// write lands at the edge that ends ack
	assign wr = '{
		we:    ack && cyc && stb && we,
		sel:   adr[2:0],
		waddr: adr[7:3],
		wdata: dat_w
	};

	always_ff @(posedge clk)
	begin
		if (rst)
			ack <= 1'b0;
		else
			ack <= req;

		if (req)
			dat_r <= rdata;
	end

endmodule

`default_nettype wire

/* design/cp0_top.sv */
`default_nettype none

module cp0_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          cyc,
	input  wire                          stb,
	input  wire                          we,
	input  wire [7:0]                    adr,
	input  wire cpu_pkg::Word_t          dat_w,
	output cpu_pkg::Word_t               dat_r,
	output logic                         ack,
	input  wire cpu_pkg::ExceptCauses_t  causes,
	input  wire cpu_pkg::Bit_t           tlbr_req,
	input  wire tlb_pkg::TLBEntry_t      tlbr_res,
	input  wire cpu_pkg::Bit_t           tlbp_req,
	input  wire cpu_pkg::Word_t          tlbp_res,
	output logic                         redirect_valid,
	output cpu_pkg::Word_t               redirect_pc,
	output cpu_pkg::CP0Regs_t            regs,
	output logic [7:0]                   asid,
	output cpu_pkg::Bit_t                user_mode
);
	import cpu_pkg::*;

	CP0RegWriteReq_t wr;
	RegAddr_t        raddr;
	logic [2:0]      rsel;
	Word_t           rdata;
	ExceptReq_t      except_req;

	cp0_bus_port bus_port_i (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack),
		.wr    (wr),
		.raddr (raddr),
		.rsel  (rsel),
		.rdata (rdata)
	);

	except_prioritizer prioritizer_i (
		.clk        (clk),
		.rst        (rst),
		.causes     (causes),
		.regs       (regs),
		.except_req (except_req)
	);

	cp0 cp0_i (
		.clk        (clk),
		.rst        (rst),
		.raddr      (raddr),
		.rsel       (rsel),
		.wr         (wr),
		.except_req (except_req),
		.tlbr_req   (tlbr_req),
		.tlbr_res   (tlbr_res),
		.tlbp_req   (tlbp_req),
		.tlbp_res   (tlbp_res),
		.rdata      (rdata),
		.regs       (regs),
		.asid       (asid),
		.user_mode  (user_mode)
	);

	except_vector vector_i (
		.clk            (clk),
		.rst            (rst),
		.except_req     (except_req),
		.regs           (regs),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

`default_nettype wire

/* bench/cp0_assertions.sv */
`default_nettype none

module cp0_assertions (
	input wire clk,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire ack,
	input wire redirect_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else $error("ack held longer than one cycle");

	// every ack answers a request from the cycle before
	ack_after_request: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb))
		else $error("ack without a bus request in the previous cycle");

	redirect_quiet_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> !redirect_valid)
		else $error("redirect_valid high during reset");

endmodule

bind cp0_top cp0_assertions assertions_i (
	.clk            (clk),
	.rst            (rst),
	.cyc            (cyc),
	.stb            (stb),
	.ack            (ack),
	.redirect_valid (redirect_valid)
);

`default_nettype wire

/* bench/cp0_tb.sv */
`default_nettype none

`include "cpu_config.svh"

module cp0_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cpu_pkg::*;
	import tlb_pkg::*;

	logic          clk;
	logic          rst;
	logic          cyc;
	logic          stb;
	logic          we;
	logic [7:0]    adr;
	Word_t         dat_w;
	Word_t         dat_r;
	logic          ack;
	ExceptCauses_t causes;
	Bit_t          tlbr_req;
	TLBEntry_t     tlbr_res;
	Bit_t          tlbp_req;
	Word_t         tlbp_res;
	logic          redirect_valid;
	Word_t         redirect_pc;
	CP0Regs_t      regs;
	logic [7:0]    asid;
	Bit_t          user_mode;

	CP0Regs_t model;
	Word_t    cycle_cnt;
	integer   seed;
	integer   errors;
	integer   checks;
	integer   test_start;

	string reg_names [0:17] = '{"index", "random", "entry_lo0", "entry_lo1", "context",
		"page_mask", "wired", "bad_vaddr", "count", "entry_hi", "compare", "status",
		"cause", "epc", "prid", "ebase", "config0", "error_epc"};

	cp0_top dut_i (
		.clk            (clk),
		.rst            (rst),
		.cyc            (cyc),
		.stb            (stb),
		.we             (we),
		.adr            (adr),
		.dat_w          (dat_w),
		.dat_r          (dat_r),
		.ack            (ack),
		.causes         (causes),
		.tlbr_req       (tlbr_req),
		.tlbr_res       (tlbr_res),
		.tlbp_req       (tlbp_req),
		.tlbp_res       (tlbp_res),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.regs           (regs),
		.asid           (asid),
		.user_mode      (user_mode)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// count runs freely once reset is released
	always @(posedge clk)
	begin
		if (rst)
			cycle_cnt <= '0;
		else
			cycle_cnt <= cycle_cnt + 32'd1;
	end

	initial
	begin
		integer n;
		n = 0;
		while (n < 25000)
		begin
			@(posedge clk);
			n = n + 1;
		end
		$display("run did not finish within the cycle limit");
		$display("Simulation failed");
		$finish;
	end

	task automatic tick();
		@(posedge clk);
		#5;
	endtask

	task automatic check_word(input string name, input Word_t exp, input Word_t act);
		checks = checks + 1;
		if (exp !== act)
		begin
			errors = errors + 1;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_regs(input CP0Regs_t exp, input CP0Regs_t act);
		for (int i = 0; i < 18; i++)
			check_word(reg_names[i], exp[i*32 +: 32], act[i*32 +: 32]);
	endtask

	function automatic CP0Regs_t expected_regs();
		CP0Regs_t exp;
		exp = model;
		exp.count = cycle_cnt;
		return exp;
	endfunction

	task automatic report_problem(input string msg);
		errors = errors + 1;
		$display("%s", msg);
	endtask

	function automatic Word_t model_reg(input logic [4:0] a, input logic [2:0] s);
		Word_t v;
		v = `ZERO_WORD;
		if (s == 3'd1 && a == 5'd15)
			v = model.ebase;
		else if (s == 3'd0)
		begin
			case (a)
				5'd0: v = model.index;
				5'd1: v = model.random;
				5'd2: v = model.entry_lo0;
				5'd3: v = model.entry_lo1;
				5'd4: v = model.context_;
				5'd5: v = model.page_mask;
				5'd6: v = model.wired;
				5'd8: v = model.bad_vaddr;
				5'd9: v = cycle_cnt;
				5'd10: v = model.entry_hi;
				5'd11: v = model.compare;
				5'd12: v = model.status;
				5'd13: v = model.cause;
				5'd14: v = model.epc;
				5'd15: v = model.prid;
				5'd16: v = model.config0;
				5'd30: v = model.error_epc;
				default: v = `ZERO_WORD;
			endcase
		end
		return v;
	endfunction

	// software-writable fields per register at select 0
	function automatic Word_t soft_mask(input logic [4:0] a);
		case (a)
			5'd0, 5'd6: return 32'h0000_000f;
			5'd2, 5'd3, 5'd10, 5'd11, 5'd14, 5'd30: return 32'hffff_ffff;
			5'd4: return 32'hff80_0000;
			5'd5: return 32'h1fff_e000;
			5'd12: return 32'hf040_ff17;
			5'd13: return 32'h0000_0300;
			default: return `ZERO_WORD;
		endcase
	endfunction

	task automatic store_reg(input logic [4:0] a, input Word_t v);
		case (a)
			5'd0: model.index = v;
			5'd2: model.entry_lo0 = v;
			5'd3: model.entry_lo1 = v;
			5'd4: model.context_ = v;
			5'd5: model.page_mask = v;
			5'd6: model.wired = v;
			5'd10: model.entry_hi = v;
			5'd11: model.compare = v;
			5'd12: model.status = Status_t'(v);
			5'd13: model.cause = Cause_t'(v);
			5'd14: model.epc = v;
			5'd30: model.error_epc = v;
			default: ;
		endcase
	endtask

	task automatic model_write(input logic [4:0] a, input logic [2:0] s, input Word_t d);
		Word_t old;
		Word_t m;
		if (s == 3'd1 && a == 5'd15)
			model.ebase[29:12] = d[29:12];
		else if (s == 3'd0)
		begin
			old = model_reg(a, 3'd0);
			m = soft_mask(a);
			store_reg(a, (d & m) | (old & ~m));
		end
	endtask

	task automatic bus_read(input logic [4:0] a, input logic [2:0] s, output Word_t data);
		integer n;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = {a, s};
		n = 0;
		tick();
		while (!ack && n < 20)
		begin
			tick();
			n = n + 1;
		end
		if (!ack)
			report_problem("bus read got no ack within 20 cycles");
		data = dat_r;
		tick();
		cyc = 1'b0;
		stb = 1'b0;
		tick();
	endtask

	task automatic bus_write(input logic [4:0] a, input logic [2:0] s, input Word_t d);
		integer n;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = {a, s};
		dat_w = d;
		n = 0;
		tick();
		while (!ack && n < 20)
		begin
			tick();
			n = n + 1;
		end
		if (!ack)
			report_problem("bus write got no ack within 20 cycles");
		// the write lands at the edge that ends ack
		tick();
		model_write(a, s, d);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		tick();
	endtask

	task automatic predict(input ExceptCauses_t c, output bit take, output bit is_eret,
		output logic [4:0] code, output Word_t extra);
		logic [7:0] pend;
		pend = c.hw_int & model.status.im;
		take = 1'b1;
		is_eret = 1'b0;
		code = `EXCCODE_INT;
		extra = `ZERO_WORD;
		if (!c.valid)
			take = 1'b0;
		else if (|pend && model.status.ie && !model.status.exl && !model.status.erl)
			extra = {24'b0, pend};
		else if (c.if_adel)
		begin
			code = `EXCCODE_ADEL;
			extra = c.cur_pc;
		end
		else if (c.ri)
			code = `EXCCODE_RI;
		else if (c.ov)
			code = `EXCCODE_OV;
		else if (c.syscall)
			code = `EXCCODE_SYS;
		else if (c.brk)
			code = `EXCCODE_BP;
		else if (c.mem_adel || c.mem_ades || c.tlbl || c.tlbs)
		begin
			extra = c.bad_addr;
			if (c.mem_adel)
				code = `EXCCODE_ADEL;
			else if (c.mem_ades)
				code = `EXCCODE_ADES;
			else if (c.tlbl)
				code = `EXCCODE_TLBL;
			else
				code = `EXCCODE_TLBS;
		end
		else if (c.eret)
			is_eret = 1'b1;
		else
			take = 1'b0;
	endtask

	function automatic Word_t expected_target(input bit is_eret);
		if (is_eret)
			return model.status.erl ? model.error_epc : model.epc;
		if (model.status.bev)
			return 32'hbfc0_0380;
		return {model.ebase[31:12], 12'h180};
	endfunction

	task automatic model_except(input logic [4:0] code, input Word_t extra, input bit ds,
		input Word_t pc);
		if (!model.status.exl)
		begin
			model.cause.bd = ds;
			model.epc = ds ? pc - 32'd4 : pc;
		end
		model.status.exl = 1'b1;
		model.cause.exc_code = code;
		model.cause.ce = 2'b00;
		if (code == `EXCCODE_INT)
			model.cause.ip = extra[7:0];
		if (code == `EXCCODE_ADEL || code == `EXCCODE_ADES || code == `EXCCODE_TLBL ||
			code == `EXCCODE_TLBS)
			model.bad_vaddr = extra;
		if (code == `EXCCODE_TLBL || code == `EXCCODE_TLBS)
		begin
			model.context_[22:4] = extra[31:13];
			model.entry_hi[31:13] = extra[31:13];
		end
	endtask

	task automatic fire(input ExceptCauses_t c);
		bit         take;
		bit         is_eret;
		bit         seen;
		logic [4:0] code;
		Word_t      extra;
		Word_t      target;
		integer     n;
		predict(c, take, is_eret, code, extra);
		target = expected_target(is_eret);
		causes = c;
		tick();
		causes = '0;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 4)
		begin
			tick();
			n = n + 1;
			if (redirect_valid)
				seen = 1'b1;
		end
		if (take && !seen)
			report_problem("no redirect within 4 cycles of an exception request");
		else if (!take && seen)
			report_problem("redirect raised for a request that should be ignored");
		else if (take)
		begin
			// causes are sampled one edge before the loop starts
			if (n != 1)
				report_problem("redirect did not follow the request by two edges");
			check_word("redirect_pc", target, redirect_pc);
			if (is_eret)
			begin
				if (model.status.erl)
					model.status.erl = 1'b0;
				else
					model.status.exl = 1'b0;
			end
			else
				model_except(code, extra, c.delayslot, c.cur_pc);
		end
		check_regs(expected_regs(), regs);
	endtask

	task automatic random_causes(output ExceptCauses_t c);
		c = '0;
		c.valid = 1'b1;
		c.cur_pc = $random(seed) & 32'hffff_fffc;
		c.delayslot = 1'($random(seed));
		c.bad_addr = $random(seed);
	endtask

	task automatic set_cause(inout ExceptCauses_t c, input integer k);
		case (k)
			0: c.if_adel = 1'b1;
			1: c.ri = 1'b1;
			2: c.ov = 1'b1;
			3: c.syscall = 1'b1;
			4: c.brk = 1'b1;
			5: c.mem_adel = 1'b1;
			6: c.mem_ades = 1'b1;
			7: c.tlbl = 1'b1;
			default: c.tlbs = 1'b1;
		endcase
	endtask

	initial
	begin
		ExceptCauses_t c;
		Word_t         data;
		Word_t         c0;
		logic [4:0]    a;
		logic [95:0]   rnd;
		integer        k;
		integer        bits;
		Bit_t          um_exp;

		seed = 32'h2756;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		causes = '0;
		tlbr_req = 1'b0;
		tlbr_res = '0;
		tlbp_req = 1'b0;
		tlbp_res = '0;
		model = '0;
		model.random = 32'd15;
		model.status = Status_t'(32'h1040_0000);
		model.ebase = 32'h8000_0001;
		repeat (8) @(posedge clk);
		#5;
		rst = 1'b0;

		test_start = errors;
		for (int i = 0; i < 32; i++)
		begin
			a = i[4:0];
			c0 = cycle_cnt;
			bus_read(a, 3'd0, data);
			if (a == 5'd9)
			begin
				checks = checks + 1;
				if (data < c0 || data > c0 + 32'd1)
				begin
					errors = errors + 1;
					$display("Fail count expected %h to %h actual %h", c0, c0 + 32'd1, data);
				end
			end
			else
				check_word($sformatf("reg%0d", i), model_reg(a, 3'd0), data);
		end
		bus_read(5'd15, 3'd1, data);
		check_word("ebase", 32'h8000_0001, data);
		check_regs(expected_regs(), regs);
		$display("test 1 reset values: %0d errors", errors - test_start);

		test_start = errors;
		for (int i = 0; i < 40; i++)
		begin
			a = 5'($random(seed));
			bus_write(a, 3'd0, $random(seed));
			bus_read(a, 3'd0, data);
			if (a != 5'd9)
				check_word($sformatf("reg%0d", a), model_reg(a, 3'd0), data);
		end
		for (int i = 0; i < 4; i++)
		begin
			bus_write(5'd15, 3'd1, $random(seed));
			bus_read(5'd15, 3'd1, data);
			check_word("ebase", model.ebase, data);
		end
		// every combination of um, erl and exl
		for (int i = 0; i < 8; i++)
		begin
			bus_write(5'd12, 3'd0, {27'b0, i[2], 1'b0, i[1], i[0], 1'b0});
			um_exp = model.status.um && !model.status.erl && !model.status.exl;
			check_word("user_mode", Word_t'(um_exp), Word_t'(user_mode));
		end
		check_regs(expected_regs(), regs);
		$display("test 2 masked writes: %0d errors", errors - test_start);

		test_start = errors;
		for (int i = 0; i < 12; i++)
		begin
			bus_write(5'd12, 3'd0, $random(seed) & 32'h0040_0000);
			bus_write(5'd15, 3'd1, $random(seed));
			random_causes(c);
			set_cause(c, $unsigned($random(seed)) % 9);
			fire(c);
			// nested exception keeps epc
			random_causes(c);
			set_cause(c, $unsigned($random(seed)) % 9);
			fire(c);
		end
		$display("test 3 exception entry: %0d errors", errors - test_start);

		test_start = errors;
		for (int i = 0; i < 10; i++)
		begin
			bus_write(5'd12, 3'd0, 32'h0);
			random_causes(c);
			bits = $random(seed) & 32'h1ff;
			if (bits == 0)
				bits = 1;
			for (k = 0; k < 9; k++)
				if (bits[k])
					set_cause(c, k);
			fire(c);
		end
		bus_write(5'd12, 3'd0, 32'h0000_ff00);
		random_causes(c);
		c.hw_int = 8'($random(seed)) | 8'h01;
		fire(c);
		bus_write(5'd12, 3'd0, 32'h0000_ff03);
		fire(c);
		bus_write(5'd12, 3'd0, 32'h0000_ff01);
		fire(c);
		$display("test 4 priority and interrupt gating: %0d errors", errors - test_start);

		test_start = errors;
		bus_write(5'd12, 3'd0, 32'h0);
		random_causes(c);
		c.syscall = 1'b1;
		fire(c);
		random_causes(c);
		c.eret = 1'b1;
		fire(c);
		bus_write(5'd30, 3'd0, $random(seed));
		bus_write(5'd12, 3'd0, 32'h0000_0006);
		random_causes(c);
		c.eret = 1'b1;
		fire(c);
		$display("test 5 eret: %0d errors", errors - test_start);

		test_start = errors;
		for (int i = 0; i < 6; i++)
		begin
			rnd = {$random(seed), $random(seed), $random(seed)};
			tlbr_res = rnd[77:0];
			tlbr_req = 1'b1;
			tick();
			tlbr_req = 1'b0;
			model.entry_hi = {tlbr_res.vpn2, 5'b0, tlbr_res.asid};
			model.entry_lo0 = {6'b0, tlbr_res.pfn0, tlbr_res.c0, tlbr_res.d0,
				tlbr_res.v0, tlbr_res.G};
			model.entry_lo1 = {6'b0, tlbr_res.pfn1, tlbr_res.c1, tlbr_res.d1,
				tlbr_res.v1, tlbr_res.G};
			check_regs(expected_regs(), regs);
			check_word("asid", {24'b0, tlbr_res.asid}, {24'b0, asid});
			tlbp_res = $random(seed);
			tlbp_req = 1'b1;
			tick();
			tlbp_req = 1'b0;
			model.index = tlbp_res;
			check_regs(expected_regs(), regs);
		end
		$display("test 6 tlb results: %0d errors", errors - test_start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/cpu_pkg.sv
common/tlb_pkg.sv
cp0/cp0_write_mask.sv
cp0/cp0.sv
design/except_prioritizer.sv
design/except_vector.sv
design/cp0_bus_port.sv
design/cp0_top.sv
bench/cp0_assertions.sv
bench/cp0_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cp0_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
